//--- uart_loopback.f
+incdir+src
src/uart_frame_pkg.sv
src/uart_ctrl_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_loopback.sv
dv/uart_loopback_tb.sv

//--- Makefile
# Verilator build and run for the UART loopback testbench

VERILATOR ?= verilator
TOP       ?= uart_loopback_tb
FILELIST  ?= uart_loopback.f
LOG       ?= sim.log
VFLAGS    ?=

RTL_TOP  := uart_loopback
RTL_SRCS := src/uart_frame_pkg.sv src/uart_ctrl_pkg.sv src/uart_tx.sv \
            src/uart_rx.sv src/uart_loopback.sv
SRCS     := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) src/uart_defines.svh $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -Isrc $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/uart_loopback_tb.sv
`include "uart_defines.svh"

module uart_loopback_tb
	import uart_frame_pkg::*;
	import uart_ctrl_pkg::*;
();

	localparam int CPB          = `UART_CLOCKS_PER_BIT;
	localparam int FRAME_CYCLES = `UART_FRAME_BITS * CPB;  // start edge to busy low
	localparam int RX_LATENCY   = `UART_SYNC_STAGES + (`UART_FRAME_BITS - 1) * CPB + CPB / 2;
	localparam int NUM_FRAMES   = 26;  // 1 + 20 + 1 + 3 + 1
	localparam int CYCLE_LIMIT  = (NUM_FRAMES + 4) * FRAME_CYCLES * 2;

	logic       clk;
	logic       reset;
	logic       i_enable;
	uart_data_t i_data;
	logic       i_loopback;
	logic       i_serial;
	logic       o_busy;
	logic       o_serial;
	uart_data_t o_rx_data;
	logic       o_rx_valid;
	logic       o_rx_error;

	int          cycle;             // rising edges since time zero
	int          errors;            // procedural checks
	int          sva_errors;        // concurrent checks
	int          valid_count;
	int          last_valid_cycle;
	uart_data_t  last_data;
	logic        last_error;
	logic [31:0] lcg_state;
	int          test_num;
	int          tests_ok;
	int          test_err0;
	string       test_name;

	uart_loopback uut (
		.clk        (clk),
		.reset      (reset),
		.i_enable   (i_enable),
		.i_data     (i_data),
		.i_loopback (i_loopback),
		.i_serial   (i_serial),
		.o_busy     (o_busy),
		.o_serial   (o_serial),
		.o_rx_data  (o_rx_data),
		.o_rx_valid (o_rx_valid),
		.o_rx_error (o_rx_error)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// rx results captured mid cycle, tests read them back at drive points
	always @(negedge clk) begin
		if (o_rx_valid === 1'b1) begin
			valid_count      = valid_count + 1;
			last_valid_cycle = cycle;
			last_data        = o_rx_data;
			last_error       = o_rx_error;
		end
	end

	assert property (@(posedge clk) disable iff (reset) o_rx_error |-> o_rx_valid)
		else begin
			$display("o_rx_error went high without o_rx_valid");
			sva_errors++;
		end

	assert property (@(posedge clk) disable iff (reset) o_rx_valid |=> !o_rx_valid)
		else begin
			$display("o_rx_valid stayed high for more than one cycle");
			sva_errors++;
		end

	initial begin
		wait (cycle >= CYCLE_LIMIT);
		$display("timeout after %0d cycles, a test never saw its frame finish", CYCLE_LIMIT);
		$display("tests failed");
		$finish;
	end

	function automatic uart_data_t next_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[`UART_DATA_WIDTH+15:16];  // upper bits, the low ones cycle fast
	endfunction

	// parity by the frame rule, bit by bit
	function automatic logic expected_parity(input uart_data_t data);
		logic p;
		p = 1'b0;
		for (int i = 0; i < `UART_DATA_WIDTH; i++) p = p ^ data[i];
		if (`UART_PARITY_ODD != 0) p = ~p;
		return p;
	endfunction

	function automatic uart_frame_u expected_frame(input uart_data_t data,
		input logic flip_parity, input logic stop);
		uart_frame_u f;
		f.fields.start  = 1'b0;
		f.fields.data   = data;
		f.fields.parity = expected_parity(data) ^ flip_parity;  // flip for a bad frame
		f.fields.stop   = stop;
		return f;
	endfunction

	task automatic check_hex(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("** Error: %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_num++;
		test_name = name;
		test_err0 = errors + sva_errors;
	endtask

	task automatic end_test();
		if (errors + sva_errors == test_err0) begin
			tests_ok++;
			$display("test %0d %s: ok", test_num, test_name);
		end else begin
			$display("test %0d %s: FAIL, %0d errors", test_num, test_name,
				errors + sva_errors - test_err0);
		end
	endtask

	task automatic to_drive_point();
		@(posedge clk);
		#10;
	endtask

	// caller sits at a drive point with tx idle
	task automatic send_byte(input uart_data_t data, input bit with_ignored,
		input uart_data_t ignored);
		i_data   = data;
		i_enable = 1'b1;
		to_drive_point();  // accepted on this edge
		if (with_ignored) begin
			i_data = ignored;  // enable still high, but busy by now
			to_drive_point();
		end
		i_enable = 1'b0;
	endtask

	// follows one tx frame from its start edge to busy low, loopback on
	task automatic track_frame(input uart_data_t data, input bit sample_bits);
		uart_frame_u exp;
		int          c0;
		int          busy_cycle;
		int          count0;
		exp    = expected_frame(data, 1'b0, 1'b1);
		count0 = valid_count;
		do @(negedge clk); while (o_serial !== 1'b0);
		c0 = cycle;  // start bit went out on this cycle's edge
		if (sample_bits) begin
			for (int i = 0; i < `UART_FRAME_BITS; i++) begin
				while (cycle < c0 + i * CPB + CPB / 2) @(negedge clk);  // bit center
				check_hex($sformatf("o_serial bit %0d", i), 32'(exp.raw[i]), 32'(o_serial));
			end
		end
		do @(negedge clk); while (o_busy === 1'b1);
		busy_cycle = cycle;
		to_drive_point();
		check_hex("o_busy fall delay", FRAME_CYCLES, busy_cycle - c0);
		check_hex("o_rx_valid count", count0 + 1, valid_count);
		check_hex("o_rx_valid delay", RX_LATENCY, last_valid_cycle - c0);
		check_hex("o_rx_data", 32'(data), 32'(last_data));
		check_hex("o_rx_error", 0, 32'(last_error));
	endtask

	// drives a whole frame on i_serial, loopback off
	task automatic receive_external(input uart_frame_u frame, input logic exp_error);
		int c0;
		int count0;
		count0 = valid_count;
		c0     = cycle;
		for (int i = 0; i < `UART_FRAME_BITS; i++) begin
			i_serial = frame.raw[i];
			repeat (CPB) to_drive_point();
		end
		i_serial = 1'b1;
		check_hex("o_rx_valid count", count0 + 1, valid_count);
		check_hex("o_rx_valid delay", RX_LATENCY, last_valid_cycle - c0);
		check_hex("o_rx_data", 32'(frame.fields.data), 32'(last_data));
		check_hex("o_rx_error", 32'(exp_error), 32'(last_error));
		repeat (2 * CPB) to_drive_point();  // idle gap before the next frame
	endtask

	// nothing may leave tx or arrive at rx for a while
	task automatic expect_quiet(input int cycles);
		int   count0;
		logic line_high;
		count0    = valid_count;
		line_high = 1'b1;
		repeat (cycles) begin
			@(negedge clk);
			if (o_serial !== 1'b1) line_high = 1'b0;
		end
		to_drive_point();
		check_hex("o_rx_valid count", count0, valid_count);
		assert (line_high) else begin
			$display("o_serial left idle although no request was accepted");
			errors++;
		end
	endtask

	initial begin
		uart_data_t b;
		reset      = 1'b1;
		i_enable   = 1'b0;
		i_data     = '0;
		i_loopback = 1'b1;
		i_serial   = 1'b1;
		lcg_state  = 32'hf6f1;
		repeat (5) @(posedge clk);
		#10;
		reset = 1'b0;

		begin_test("reset state");
		repeat (4 * CPB) begin  // i_enable stays low throughout
			@(negedge clk);
			check_hex("o_serial", 1, 32'(o_serial));
			check_hex("o_busy", 0, 32'(o_busy));
			check_hex("o_rx_valid", 0, 32'(o_rx_valid));
			check_hex("o_rx_error", 0, 32'(o_rx_error));
		end
		assert (uut.u_tx.state == TX_IDLE) else begin
			$display("tx controller in %s after reset, not TX_IDLE", uut.u_tx.state.name());
			errors++;
		end
		assert (uut.u_rx.state == RX_IDLE) else begin
			$display("rx controller in %s after reset, not RX_IDLE", uut.u_rx.state.name());
			errors++;
		end
		to_drive_point();
		end_test();

		begin_test("frame shape");
		b = next_byte();
		send_byte(b, 1'b0, '0);
		track_frame(b, 1'b1);
		end_test();

		begin_test("loopback data");
		for (int n = 0; n < 20; n++) begin
			b = next_byte();
			send_byte(b, 1'b0, '0);  // right after busy fell
			track_frame(b, 1'b0);
		end
		end_test();

		begin_test("ignored request");
		b = next_byte();
		send_byte(b, 1'b1, ~b);
		track_frame(b, 1'b0);
		expect_quiet(2 * FRAME_CYCLES);  // no second frame from the dropped request
		end_test();

		begin_test("receiver errors");
		i_loopback = 1'b0;
		b = next_byte();
		receive_external(expected_frame(b, 1'b1, 1'b1), 1'b1);  // parity flipped
		b = next_byte();
		receive_external(expected_frame(b, 1'b0, 1'b0), 1'b1);  // stop low
		b = next_byte();
		receive_external(expected_frame(b, 1'b0, 1'b1), 1'b0);
		end_test();

		begin_test("glitch rejection");
		i_serial = 1'b0;
		repeat (CPB / 4) to_drive_point();  // well under half a bit
		i_serial = 1'b1;
		expect_quiet(FRAME_CYCLES + CPB);
		b = next_byte();
		receive_external(expected_frame(b, 1'b0, 1'b1), 1'b0);
		end_test();

		$display("summary: %0d of %0d tests ok, %0d check errors", tests_ok, test_num,
			errors + sva_errors);
		if ((errors + sva_errors == 0) && (tests_ok == test_num)) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- src/uart_loopback.sv
module uart_loopback
	import uart_frame_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       i_enable,    // tx request
	input  uart_data_t i_data,      // tx byte
	input  logic       i_loopback,  // 1 feeds tx back into rx
	input  logic       i_serial,    // external rx line
	output logic       o_busy,
	output logic       o_serial,    // tx line
	output uart_data_t o_rx_data,
	output logic       o_rx_valid,
	output logic       o_rx_error
);

	logic rx_line;

	// loopback select is combinational so the path adds no cycle
	assign rx_line = i_loopback ? o_serial : i_serial;

	uart_tx u_tx (
		.clk      (clk),
		.reset    (reset),
		.i_enable (i_enable),
		.i_data   (i_data),
		.o_busy   (o_busy),
		.o_serial (o_serial)
	);

	uart_rx u_rx (
		.clk        (clk),
		.reset      (reset),
		.i_serial   (rx_line),  // rx synchronizer covers the external case
		.o_rx_data  (o_rx_data),
		.o_rx_valid (o_rx_valid),
		.o_rx_error (o_rx_error)
	);

endmodule

//--- src/uart_rx.sv
`include "uart_defines.svh"

module uart_rx
	import uart_frame_pkg::*;
	import uart_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       i_serial,    // async line, idles high
	output uart_data_t o_rx_data,   // holds until the next frame
	output logic       o_rx_valid,  // one cycle per frame
	output logic       o_rx_error   // parity or stop fault, with o_rx_valid
);

	localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(`UART_CLOCKS_PER_BIT - 1);
	localparam baud_cnt_t HALF_LAST = baud_cnt_t'(`UART_CLOCKS_PER_BIT / 2 - 1);
	localparam bit_cnt_t  BODY_LAST = bit_cnt_t'(`UART_FRAME_BITS - 3);  // last data/parity idx

	logic [`UART_SYNC_STAGES-1:0] sync;  // sync[0] sees the pin first
	logic                         line;  // synchronized line
	logic                         line_q;
	logic                         fall;

	rx_state_e   state;
	baud_cnt_t   cnt;       // cycles into the current bit
	bit_cnt_t    bit_cnt;   // body bits taken so far
	logic        bit_done;  // mid-bit point of a body or stop bit
	uart_frame_u frame;     // samples so far, newest at the msb
	uart_frame_u frame_next;
	logic        bad_parity;

	// input synchronizer, preset to idle so reset cannot look like a start edge
	always_ff @(posedge clk) begin
		if (reset) begin
			sync   <= '1;
			line_q <= 1'b1;
		end else begin
			sync   <= {sync[`UART_SYNC_STAGES-2:0], i_serial};
			line_q <= line;
		end
	end

	assign line = sync[`UART_SYNC_STAGES-1];
	assign fall = line_q && !line;  // high to low on the synced line

	assign bit_done = (cnt == BAUD_LAST);

	// current sample shifted in ahead of time so the stop bit can be checked directly
	always_comb begin
		frame_next.raw = {line, frame.raw[`UART_FRAME_BITS-1:1]};
	end

	assign bad_parity = (frame_next.fields.parity != uart_parity(frame_next.fields.data));

	// controller and bit timing
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= RX_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					if (fall) begin
						state <= RX_START;
						cnt   <= baud_cnt_t'(1);  // the edge cycle is the first of the half bit
					end
				end
				RX_START: begin
					if (cnt == HALF_LAST) begin
						cnt     <= '0;
						bit_cnt <= '0;
						// still low at mid start, otherwise it was a glitch
						state   <= line ? RX_IDLE : RX_BITS;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_BITS: begin
					if (bit_done) begin
						cnt <= '0;
						if (bit_cnt == BODY_LAST) begin
							state <= RX_STOP;  // parity was the last body bit
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_done) begin
						cnt   <= '0;
						state <= RX_IDLE;  // rearm while the stop bit is still high
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// sample register, start bit included so the fields line up at the end
	always_ff @(posedge clk) begin
		if ((state == RX_START) && (cnt == HALF_LAST)) begin
			frame.raw <= frame_next.raw;
		end else if ((state == RX_BITS) && bit_done) begin
			frame.raw <= frame_next.raw;
		end
	end

	// result strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			o_rx_valid <= 1'b0;
			o_rx_error <= 1'b0;
		end else begin
			o_rx_valid <= (state == RX_STOP) && bit_done;
			o_rx_error <= (state == RX_STOP) && bit_done &&
				(bad_parity || !frame_next.fields.stop);
		end
	end

	// received byte
	always_ff @(posedge clk) begin
		if ((state == RX_STOP) && bit_done) begin
			o_rx_data <= frame_next.fields.data;
		end
	end

endmodule

//--- src/uart_tx.sv
`include "uart_defines.svh"

module uart_tx
	import uart_frame_pkg::*;
	import uart_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       i_enable,  // request strobe, taken only while idle
	input  uart_data_t i_data,    // captured on acceptance
	output logic       o_busy,
	output logic       o_serial   // idles high
);

	localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(`UART_CLOCKS_PER_BIT - 1);
	localparam bit_cnt_t  STOP_IDX  = bit_cnt_t'(`UART_FRAME_BITS - 1);

	tx_state_e   state;
	baud_cnt_t   baud_cnt;  // free running, never held
	logic        tick;
	bit_cnt_t    bit_cnt;   // index of the bit now on the line
	uart_frame_u frame;     // bits still to go out, lsb next
	logic        accept;
	logic        last_bit;
	logic        shift;

	// baud tick generator
	always_ff @(posedge clk) begin
		if (reset) begin
			baud_cnt <= '0;
		end else if (tick) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	assign tick = (baud_cnt == BAUD_LAST);  // one cycle in every bit time

	assign accept   = i_enable && (state == TX_IDLE);
	assign last_bit = (bit_cnt == STOP_IDX);  // stop bit is on the line

	// ARMED tick puts out the start bit, SEND ticks the rest
	assign shift = tick && ((state == TX_ARMED) || ((state == TX_SEND) && !last_bit));

	// controller
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= TX_IDLE;
		end else begin
			case (state)
				TX_IDLE: begin
					if (accept) state <= TX_ARMED;
				end
				TX_ARMED: begin
					if (tick) state <= TX_SEND;  // start bit goes out now
				end
				TX_SEND: begin
					// stop bit has had its full bit time
					if (tick && last_bit) state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// bit position, restarts with the start bit
	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
		end else if (tick && (state == TX_ARMED)) begin
			bit_cnt <= '0;
		end else if (shift) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// frame register is loaded by fields and drained as raw bits
	always_ff @(posedge clk) begin
		if (accept) begin
			frame.fields <= '{
				stop:   1'b1,
				parity: uart_parity(i_data),
				data:   i_data,
				start:  1'b0
			};
		end else if (shift) begin
			frame.raw <= {1'b1, frame.raw[`UART_FRAME_BITS-1:1]};  // refill with idle level
		end
	end

	// serial output is registered so the line has no glitches
	always_ff @(posedge clk) begin
		if (reset) begin
			o_serial <= 1'b1;
		end else if (shift) begin
			o_serial <= frame.raw[0];
		end
	end

	assign o_busy = (state != TX_IDLE);  // high from the cycle after acceptance

endmodule

//--- src/uart_ctrl_pkg.sv
`include "uart_defines.svh"

package uart_ctrl_pkg;

	// transmit controller
	typedef enum logic [1:0] {
		TX_IDLE,   // line high, ready for a request
		TX_ARMED,  // frame loaded, waiting for the next baud tick
		TX_SEND    // shifting the frame out
	} tx_state_e;

	// receive controller
	typedef enum logic [1:0] {
		RX_IDLE,   // watching for a falling edge
		RX_START,  // half bit wait then start confirm
		RX_BITS,   // data and parity samples
		RX_STOP    // stop sample and result
	} rx_state_e;

	// counter widths shared by both controllers
	localparam int BAUD_CNT_W = $clog2(`UART_CLOCKS_PER_BIT);
	localparam int BIT_CNT_W  = $clog2(`UART_FRAME_BITS);

	typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;  // cycle within a bit time
	typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;   // bit within a frame

endpackage

//--- src/uart_frame_pkg.sv
`include "uart_defines.svh"

package uart_frame_pkg;

	// one byte of payload
	typedef logic [`UART_DATA_WIDTH-1:0] uart_data_t;

	// frame as it appears on the wire with bit 0 sent first
	typedef logic [`UART_FRAME_BITS-1:0] uart_frame_raw_t;

	// same frame split into its fields, msb down
	typedef struct packed {
		logic       stop;   // idles high
		logic       parity;
		uart_data_t data;   // lsb goes out right after start
		logic       start;  // always low on a good frame
	} uart_frame_fields_t;

	// tx loads fields and shifts raw, rx shifts raw and checks fields
	typedef union packed {
		uart_frame_raw_t    raw;
		uart_frame_fields_t fields;
	} uart_frame_u;

	// xor of the data bits, flipped for odd parity
	function automatic logic uart_parity(input uart_data_t data);
		logic odd;
		odd = (`UART_PARITY_ODD != 0);
		return (^data) ^ odd;
	endfunction

endpackage

//--- src/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// payload bits carried in one frame
`define UART_DATA_WIDTH 8

// clk cycles per bit time
// kept even so the mid-bit point falls on a whole cycle
`define UART_CLOCKS_PER_BIT 8

// parity sense where 0 is even and 1 is odd
`define UART_PARITY_ODD 0

// flops between the external line and the rx logic
`define UART_SYNC_STAGES 3

// start + data + parity + stop
`define UART_FRAME_BITS (`UART_DATA_WIDTH + 3)

`endif
